// File: common/l1_cache_defines.svh
// address, tag, index and data widths and line count of the level 1 data cache

`ifndef L1_CACHE_DEFINES_SVH
`define L1_CACHE_DEFINES_SVH

// word address, no byte offset
`define L1_ADDR_WID  16
`define L1_INDEX_WID 4

// tag is what is left above the index
`define L1_TAG_WID   (`L1_ADDR_WID - `L1_INDEX_WID)

`define L1_DATA_WID  32

// one word per line, direct mapped
`define L1_DEPTH     16

`endif

// File: common/l1_cache_pkg.sv
// vector typedefs and state enums of the level 1 data cache
`default_nettype none

`include "l1_cache_defines.svh"

package l1_cache_pkg;

    typedef logic [`L1_ADDR_WID-1:0]  addr_t;
    typedef logic [`L1_TAG_WID-1:0]   tag_t;
    typedef logic [`L1_INDEX_WID-1:0] index_t;
    typedef logic [`L1_DATA_WID-1:0]  data_t;

    // line coherence state
    typedef enum logic [1:0] {
        MESI_I,
        MESI_S,
        MESI_E,
        MESI_M
    } mesi_e;

    // processor side controller
    typedef enum logic [2:0] {
        P_IDLE,
        P_WRITEBACK,
        P_FILL,
        P_WRITE,
        P_INVAL,
        P_DONE
    } proc_state_e;

endpackage

`default_nettype wire

// File: hdl/l1_dcache_top.sv
// top level of the level 1 data cache, store plus MESI table and both controllers
`default_nettype none
`timescale 1ns/100ps

module l1_dcache_top (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         cpu_rd,
    input  wire                         cpu_wr,
    input  wire  l1_cache_pkg::addr_t   cpu_addr,
    input  wire  l1_cache_pkg::data_t   cpu_wdata,
    output l1_cache_pkg::data_t         cpu_rdata,
    output logic                        cpu_rdata_valid,
    output logic                        cpu_wr_done,
    output logic                        bus_req,
    input  wire                         bus_gnt,
    output logic                        bus_rd_out,
    output logic                        bus_inv_out,
    output l1_cache_pkg::addr_t         bus_addr,
    input  wire                         all_inval_done,
    output logic                        lv2_rd,
    output logic                        lv2_wr,
    output l1_cache_pkg::data_t         lv2_wdata,
    input  wire  l1_cache_pkg::data_t   lv2_rdata,
    input  wire                         lv2_data_valid,
    input  wire                         shared_in,
    input  wire                         lv2_wr_done,
    input  wire                         snoop_rd,
    input  wire                         snoop_inv,
    input  wire  l1_cache_pkg::addr_t   snoop_addr,
    output logic                        shared_local,
    output l1_cache_pkg::data_t         snoop_data,
    output logic                        snoop_data_valid,
    output logic                        inval_done
);
    import l1_cache_pkg::*;

    index_t proc_index;
    index_t snoop_index;
    tag_t   proc_tag;
    tag_t   snoop_tag;
    tag_t   proc_wr_tag;
    mesi_e  proc_mesi;
    mesi_e  snoop_mesi;
    mesi_e  proc_wr_mesi;
    mesi_e  proc_next_mesi;
    mesi_e  snoop_next_mesi;
    data_t  proc_data;
    data_t  snoop_data_rd;
    data_t  proc_wr_data;
    logic   proc_we;
    logic   snoop_mesi_we;
    logic   fill_event;
    logic   write_event;
    logic   snoop_rd_event;
    logic   snoop_inv_event;

    cache_store u_store (
        .clk(clk), .rst_n(rst_n),
        .proc_index(proc_index), .snoop_index(snoop_index),
        .proc_tag(proc_tag), .snoop_tag(snoop_tag),
        .proc_mesi(proc_mesi), .snoop_mesi(snoop_mesi),
        .proc_data(proc_data), .snoop_data_rd(snoop_data_rd),
        .proc_we(proc_we), .proc_wr_tag(proc_wr_tag),
        .proc_wr_data(proc_wr_data), .proc_wr_mesi(proc_wr_mesi),
        .snoop_mesi_we(snoop_mesi_we), .snoop_wr_mesi(snoop_next_mesi)
    );

    // snoop state feeds the table, processor side needs no old state
    mesi_next u_mesi (
        .cur_mesi(snoop_mesi),
        .fill_event(fill_event), .write_event(write_event), .shared_in(shared_in),
        .snoop_rd_event(snoop_rd_event), .snoop_inv_event(snoop_inv_event),
        .proc_next_mesi(proc_next_mesi), .snoop_next_mesi(snoop_next_mesi)
    );

    proc_ctrl u_proc (
        .clk(clk), .rst_n(rst_n),
        .cpu_rd(cpu_rd), .cpu_wr(cpu_wr), .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata),
        .cpu_rdata(cpu_rdata), .cpu_rdata_valid(cpu_rdata_valid),
        .cpu_wr_done(cpu_wr_done),
        .bus_req(bus_req), .bus_gnt(bus_gnt),
        .bus_rd_out(bus_rd_out), .bus_inv_out(bus_inv_out), .bus_addr(bus_addr),
        .all_inval_done(all_inval_done),
        .lv2_rd(lv2_rd), .lv2_wr(lv2_wr), .lv2_wdata(lv2_wdata),
        .lv2_rdata(lv2_rdata), .lv2_data_valid(lv2_data_valid), .shared_in(shared_in),
        .lv2_wr_done(lv2_wr_done),
        .proc_index(proc_index), .proc_tag(proc_tag),
        .proc_mesi(proc_mesi), .proc_data(proc_data),
        .proc_we(proc_we), .proc_wr_tag(proc_wr_tag),
        .proc_wr_data(proc_wr_data), .proc_wr_mesi(proc_wr_mesi),
        .fill_event(fill_event), .write_event(write_event),
        .proc_next_mesi(proc_next_mesi)
    );

    snoop_ctrl u_snoop (
        .clk(clk), .rst_n(rst_n),
        .snoop_rd(snoop_rd), .snoop_inv(snoop_inv), .snoop_addr(snoop_addr),
        .shared_local(shared_local), .snoop_data(snoop_data),
        .snoop_data_valid(snoop_data_valid), .inval_done(inval_done),
        .snoop_index(snoop_index), .snoop_tag(snoop_tag),
        .snoop_mesi(snoop_mesi), .snoop_data_rd(snoop_data_rd),
        .snoop_mesi_we(snoop_mesi_we), .snoop_rd_event(snoop_rd_event),
        .snoop_inv_event(snoop_inv_event), .snoop_next_mesi(snoop_next_mesi)
    );

endmodule

`default_nettype wire

// File: l1_dcache/cache_store.sv
// data and tag/MESI arrays with processor and snoop lookups and write ports
`default_nettype none
`timescale 1ns/100ps

`include "l1_cache_defines.svh"

module cache_store (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire  l1_cache_pkg::index_t  proc_index,
    input  wire  l1_cache_pkg::index_t  snoop_index,
    output l1_cache_pkg::tag_t          proc_tag,
    output l1_cache_pkg::tag_t          snoop_tag,
    output l1_cache_pkg::mesi_e         proc_mesi,
    output l1_cache_pkg::mesi_e         snoop_mesi,
    output l1_cache_pkg::data_t         proc_data,
    output l1_cache_pkg::data_t         snoop_data_rd,
    input  wire                         proc_we,
    input  wire  l1_cache_pkg::tag_t    proc_wr_tag,
    input  wire  l1_cache_pkg::data_t   proc_wr_data,
    input  wire  l1_cache_pkg::mesi_e   proc_wr_mesi,
    input  wire                         snoop_mesi_we,
    input  wire  l1_cache_pkg::mesi_e   snoop_wr_mesi
);
    import l1_cache_pkg::*;

    data_t data_mem [`L1_DEPTH];
    tag_t  tag_mem  [`L1_DEPTH];
    mesi_e mesi_mem [`L1_DEPTH];

    // combinational lookups, one per side
    assign proc_tag      = tag_mem[proc_index];
    assign proc_mesi     = mesi_mem[proc_index];
    assign proc_data     = data_mem[proc_index];
    assign snoop_tag     = tag_mem[snoop_index];
    assign snoop_mesi    = mesi_mem[snoop_index];
    assign snoop_data_rd = data_mem[snoop_index];

    // state array, all lines invalid out of reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `L1_DEPTH; i++) begin
                mesi_mem[i] <= MESI_I;
            end
        end else begin
            if (snoop_mesi_we) begin
                mesi_mem[snoop_index] <= snoop_wr_mesi;
            end
            if (proc_we) begin
                mesi_mem[proc_index] <= proc_wr_mesi;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (proc_we) begin
            tag_mem[proc_index]  <= proc_wr_tag;
            data_mem[proc_index] <= proc_wr_data;
        end
    end

endmodule

`default_nettype wire

// File: l1_dcache/mesi_next.sv
// MESI next-state table for processor and snoop events
`default_nettype none
`timescale 1ns/100ps

module mesi_next (
    input  wire  l1_cache_pkg::mesi_e cur_mesi,
    input  wire                       fill_event,
    input  wire                       write_event,
    input  wire                       shared_in,
    input  wire                       snoop_rd_event,
    input  wire                       snoop_inv_event,
    output l1_cache_pkg::mesi_e       proc_next_mesi,
    output l1_cache_pkg::mesi_e       snoop_next_mesi
);
    import l1_cache_pkg::*;

    // processor side does not depend on the old state
    always_comb begin
        if (write_event) begin
            proc_next_mesi = MESI_M;
        end else if (fill_event) begin
            proc_next_mesi = shared_in ? MESI_S : MESI_E;
        end else begin
            proc_next_mesi = MESI_I;
        end
    end

    // invalidate wins over a remote read
    always_comb begin
        snoop_next_mesi = cur_mesi;
        if (snoop_inv_event) begin
            snoop_next_mesi = MESI_I;
        end else if (snoop_rd_event && (cur_mesi == MESI_E || cur_mesi == MESI_M)) begin
            snoop_next_mesi = MESI_S;
        end
    end

endmodule

`default_nettype wire

// File: l1_dcache/proc_ctrl.sv
// processor side FSM for hits, write-back, fill and invalidate
`default_nettype none
`timescale 1ns/100ps

`include "l1_cache_defines.svh"

module proc_ctrl (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         cpu_rd,
    input  wire                         cpu_wr,
    input  wire  l1_cache_pkg::addr_t   cpu_addr,
    input  wire  l1_cache_pkg::data_t   cpu_wdata,
    output l1_cache_pkg::data_t         cpu_rdata,
    output logic                        cpu_rdata_valid,
    output logic                        cpu_wr_done,
    output logic                        bus_req,
    input  wire                         bus_gnt,
    output logic                        bus_rd_out,
    output logic                        bus_inv_out,
    output l1_cache_pkg::addr_t         bus_addr,
    input  wire                         all_inval_done,
    output logic                        lv2_rd,
    output logic                        lv2_wr,
    output l1_cache_pkg::data_t         lv2_wdata,
    input  wire  l1_cache_pkg::data_t   lv2_rdata,
    input  wire                         lv2_data_valid,
    input  wire                         shared_in,
    input  wire                         lv2_wr_done,
    output l1_cache_pkg::index_t        proc_index,
    input  wire  l1_cache_pkg::tag_t    proc_tag,
    input  wire  l1_cache_pkg::mesi_e   proc_mesi,
    input  wire  l1_cache_pkg::data_t   proc_data,
    output logic                        proc_we,
    output l1_cache_pkg::tag_t          proc_wr_tag,
    output l1_cache_pkg::data_t         proc_wr_data,
    output l1_cache_pkg::mesi_e         proc_wr_mesi,
    output logic                        fill_event,
    output logic                        write_event,
    input  wire  l1_cache_pkg::mesi_e   proc_next_mesi
);
    import l1_cache_pkg::*;

    proc_state_e state;
    tag_t        cpu_tag;
    index_t      cpu_index;
    logic        hit;
    logic        need_inv;

    assign cpu_tag   = cpu_addr[`L1_ADDR_WID-1 -: `L1_TAG_WID];
    assign cpu_index = cpu_addr[`L1_INDEX_WID-1:0];
    assign hit       = (proc_mesi != MESI_I) && (proc_tag == cpu_tag);

    // ========================================
    // bus and level 2 commands, only under grant
    // ========================================
    assign lv2_wr      = (state == P_WRITEBACK) && bus_gnt;
    assign lv2_rd      = (state == P_FILL) && bus_gnt;
    assign bus_rd_out  = lv2_rd;
    assign bus_inv_out = (state == P_INVAL) && bus_gnt;
    // victim address while writing back
    assign bus_addr    = (state == P_WRITEBACK) ? {proc_tag, cpu_index} : cpu_addr;
    assign lv2_wdata   = proc_data;

    // store update
    assign fill_event   = (state == P_FILL) && bus_gnt && lv2_data_valid;
    assign write_event  = (state == P_WRITE) && bus_gnt && !need_inv;
    assign proc_we      = fill_event || write_event;
    assign proc_index   = cpu_index;
    assign proc_wr_tag  = cpu_tag;
    assign proc_wr_data = fill_event ? lv2_rdata : cpu_wdata;
    assign proc_wr_mesi = proc_next_mesi;

    // ========================================
    // state machine
    // ========================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state           <= P_IDLE;
            bus_req         <= 1'b0;
            cpu_rdata_valid <= 1'b0;
            cpu_wr_done     <= 1'b0;
            need_inv        <= 1'b0;
        end else begin
            cpu_rdata_valid <= 1'b0;
            cpu_wr_done     <= 1'b0;
            case (state)
                P_IDLE: begin
                    if (cpu_rd && hit) begin
                        cpu_rdata_valid <= 1'b1;
                        state           <= P_DONE;
                    end else if (cpu_rd || cpu_wr) begin
                        bus_req  <= 1'b1;
                        need_inv <= hit && (proc_mesi == MESI_S);
                        if (cpu_wr && hit) begin
                            state <= P_WRITE;
                        end else if (proc_mesi == MESI_M) begin
                            state <= P_WRITEBACK;
                        end else begin
                            state <= P_FILL;
                        end
                    end
                end
                P_WRITEBACK: begin
                    if (bus_gnt && lv2_wr_done) begin
                        state <= P_FILL;
                    end
                end
                P_FILL: begin
                    if (fill_event) begin
                        if (cpu_rd) begin
                            cpu_rdata_valid <= 1'b1;
                            bus_req         <= 1'b0;
                            state           <= P_DONE;
                        end else begin
                            // another cache holds it, so the write must invalidate
                            need_inv <= shared_in;
                            state    <= P_WRITE;
                        end
                    end
                end
                P_WRITE: begin
                    if (bus_gnt && need_inv) begin
                        state <= P_INVAL;
                    end else if (bus_gnt) begin
                        cpu_wr_done <= 1'b1;
                        bus_req     <= 1'b0;
                        state       <= P_DONE;
                    end
                end
                P_INVAL: begin
                    if (bus_gnt && all_inval_done) begin
                        need_inv <= 1'b0;
                        state    <= P_WRITE;
                    end
                end
                P_DONE: begin
                    state <= P_IDLE;
                end
                default: begin
                    state <= P_IDLE;
                end
            endcase
        end
    end

    // read word, hit path or fill path
    always_ff @(posedge clk) begin
        if (state == P_IDLE && cpu_rd && hit) begin
            cpu_rdata <= proc_data;
        end else if (fill_event && cpu_rd) begin
            cpu_rdata <= lv2_rdata;
        end
    end

endmodule

`default_nettype wire

// File: l1_dcache/snoop_ctrl.sv
// snoop side responder for remote bus reads and invalidates
`default_nettype none
`timescale 1ns/100ps

`include "l1_cache_defines.svh"

module snoop_ctrl (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         snoop_rd,
    input  wire                         snoop_inv,
    input  wire  l1_cache_pkg::addr_t   snoop_addr,
    output logic                        shared_local,
    output l1_cache_pkg::data_t         snoop_data,
    output logic                        snoop_data_valid,
    output logic                        inval_done,
    output l1_cache_pkg::index_t        snoop_index,
    input  wire  l1_cache_pkg::tag_t    snoop_tag,
    input  wire  l1_cache_pkg::mesi_e   snoop_mesi,
    input  wire  l1_cache_pkg::data_t   snoop_data_rd,
    output logic                        snoop_mesi_we,
    output logic                        snoop_rd_event,
    output logic                        snoop_inv_event,
    input  wire  l1_cache_pkg::mesi_e   snoop_next_mesi
);
    import l1_cache_pkg::*;

    logic snoop_hit;

    assign snoop_index = snoop_addr[`L1_INDEX_WID-1:0];
    assign snoop_hit   = (snoop_mesi != MESI_I) &&
                         (snoop_tag == snoop_addr[`L1_ADDR_WID-1 -: `L1_TAG_WID]);

    // state change only for a line we hold
    assign snoop_rd_event  = snoop_rd && snoop_hit;
    assign snoop_inv_event = snoop_inv && snoop_hit;
    assign snoop_mesi_we   = (snoop_rd_event || snoop_inv_event) && (snoop_next_mesi != snoop_mesi);

    // one cycle replies
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            shared_local     <= 1'b0;
            snoop_data_valid <= 1'b0;
            inval_done       <= 1'b0;
        end else begin
            shared_local     <= snoop_rd_event;
            snoop_data_valid <= snoop_rd_event;
            // acknowledged on a miss too
            inval_done       <= snoop_inv;
        end
    end

    always_ff @(posedge clk) begin
        if (snoop_rd_event) begin
            snoop_data <= snoop_data_rd;
        end
    end

endmodule

`default_nettype wire

// File: l1_dcache_top.f
+incdir+common
common/l1_cache_pkg.sv
l1_dcache/cache_store.sv
l1_dcache/mesi_next.sv
l1_dcache/proc_ctrl.sv
l1_dcache/snoop_ctrl.sv
hdl/l1_dcache_top.sv
tests/l1_dcache_asserts.sv
tests/l1_dcache_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f l1_dcache_top.f \
    --top-module l1_dcache_tb -o sim_l1_dcache
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_l1_dcache > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Done: no errors$" sim.log; then
    exit 0
fi
exit 1

// File: tests/l1_dcache_asserts.sv
// bus, CPU pulse and snoop invalidate assertions bound to the cache top level
`default_nettype none
`timescale 1ns/100ps

module l1_dcache_asserts (
    input wire clk,
    input wire rst_n,
    input wire bus_gnt,
    input wire bus_rd_out,
    input wire bus_inv_out,
    input wire lv2_rd,
    input wire lv2_wr,
    input wire cpu_rdata_valid,
    input wire cpu_wr_done,
    input wire snoop_inv,
    input wire inval_done
);

    // bus commands only under grant
    assert property (@(posedge clk) disable iff (!rst_n)
        (bus_rd_out || bus_inv_out || lv2_rd || lv2_wr) |-> bus_gnt)
        else $error("bus command without bus_gnt");

    assert property (@(posedge clk) disable iff (!rst_n)
        cpu_rdata_valid |=> !cpu_rdata_valid)
        else $error("cpu_rdata_valid longer than one cycle");

    assert property (@(posedge clk) disable iff (!rst_n)
        cpu_wr_done |=> !cpu_wr_done)
        else $error("cpu_wr_done longer than one cycle");

    assert property (@(posedge clk) disable iff (!rst_n)
        !(cpu_rdata_valid && cpu_wr_done))
        else $error("read and write completion together");

    assert property (@(posedge clk) disable iff (!rst_n)
        snoop_inv |=> inval_done)
        else $error("snoop_inv not acknowledged");

endmodule

bind l1_dcache_top l1_dcache_asserts u_asserts (.*);

`default_nettype wire

// File: tests/l1_dcache_tb.sv
// testbench for the level 1 data cache with level 2, bus grant and reference models
`default_nettype none
`timescale 1ns/100ps

module l1_dcache_tb;
    import l1_cache_pkg::*;

    localparam int NUM_OPS = 17;

    logic  clk = 1'b0;
    logic  rst_n = 1'b0;
    logic  cpu_rd = 1'b0;
    logic  cpu_wr = 1'b0;
    addr_t cpu_addr = '0;
    data_t cpu_wdata = '0;
    logic  bus_gnt = 1'b0;
    logic  all_inval_done = 1'b0;
    data_t lv2_rdata = '0;
    logic  lv2_data_valid = 1'b0;
    logic  shared_in = 1'b0;
    logic  lv2_wr_done = 1'b0;
    logic  snoop_rd = 1'b0;
    logic  snoop_inv = 1'b0;
    addr_t snoop_addr = '0;

    data_t cpu_rdata, lv2_wdata, snoop_data;
    addr_t bus_addr;
    logic  cpu_rdata_valid, cpu_wr_done, bus_req, bus_rd_out, bus_inv_out;
    logic  lv2_rd, lv2_wr, shared_local, snoop_data_valid, inval_done;

    // level 2 contents and the expected contents of memory
    data_t l2_mem  [1 << 16];
    data_t ref_mem [1 << 16];
    logic  l2_filled = 1'b0;
    logic  [31:0] lfsr_state = 32'hc68eeb8f;
    logic  [31:0] rnd;
    int    rd_wait = 0;
    int    wr_wait = 0;
    int    gnt_wait = 0;
    logic  gnt_armed = 1'b0;
    logic  fill_shared = 1'b0;

    // bus activity seen by the monitor
    int    cyc = 0;
    int    n_lv2_rd = 0;
    int    n_lv2_wr = 0;
    int    n_bus_rd = 0;
    int    n_bus_req = 0;
    int    n_inv = 0;
    int    last_rd_cyc = 0;
    int    last_wr_cyc = 0;
    addr_t last_wr_addr = '0;
    data_t last_wr_data = '0;
    int    errors = 0;

    l1_dcache_top UUT (.*);

    initial begin
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // ========================================
    // level 2 and bus grant models
    // ========================================
    always @(posedge clk) begin
        lv2_data_valid <= 1'b0;
        lv2_wr_done    <= 1'b0;
        all_inval_done <= 1'b0;
        if (!rst_n) begin
            if (!l2_filled) begin
                for (int a = 0; a < (1 << 16); a++) begin
                    take_bits(32, rnd);
                    l2_mem[a] = rnd;
                end
                l2_filled = 1'b1;
            end
            bus_gnt   <= 1'b0;
            gnt_armed <= 1'b0;
        end else begin
            if (!bus_req) begin
                bus_gnt   <= 1'b0;
                gnt_armed <= 1'b0;
            end else if (!bus_gnt) begin
                if (!gnt_armed) begin
                    take_bits(2, rnd);
                    gnt_wait  <= int'(rnd);
                    gnt_armed <= 1'b1;
                end else if (gnt_wait == 0) begin
                    bus_gnt <= 1'b1;
                end else begin
                    gnt_wait <= gnt_wait - 1;
                end
            end
            if (lv2_rd && !lv2_data_valid) begin
                if (rd_wait == 3) begin
                    lv2_rdata      <= l2_mem[bus_addr];
                    shared_in      <= fill_shared;
                    lv2_data_valid <= 1'b1;
                    rd_wait        <= 0;
                end else begin
                    rd_wait <= rd_wait + 1;
                end
            end
            if (lv2_wr && !lv2_wr_done) begin
                if (wr_wait == 2) begin
                    l2_mem[bus_addr] = lv2_wdata;
                    lv2_wr_done <= 1'b1;
                    wr_wait     <= 0;
                end else begin
                    wr_wait <= wr_wait + 1;
                end
            end
            if (bus_inv_out && !all_inval_done) begin
                all_inval_done <= 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (lv2_rd) begin
            n_lv2_rd    <= n_lv2_rd + 1;
            last_rd_cyc <= cyc;
        end
        if (lv2_wr) begin
            n_lv2_wr     <= n_lv2_wr + 1;
            last_wr_cyc  <= cyc;
            last_wr_addr <= bus_addr;
            last_wr_data <= lv2_wdata;
        end
        if (bus_rd_out) begin
            n_bus_rd <= n_bus_rd + 1;
        end
        if (bus_req) begin
            n_bus_req <= n_bus_req + 1;
        end
        if (bus_inv_out) begin
            n_inv <= n_inv + 1;
        end
    end

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            $display("Error %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            $display("Error: %s", what);
            errors++;
        end
    endtask

    task automatic cpu_read(input addr_t addr, input logic exp_hit);
        int n;
        int rd0;
        int brd0;
        int req0;
        n = 0;
        @(negedge clk);
        rd0  = n_lv2_rd;
        brd0 = n_bus_rd;
        req0 = n_bus_req;
        @(posedge clk);
        cpu_rd   <= 1'b1;
        cpu_addr <= addr;
        do begin
            @(negedge clk);
            n++;
        end while (!cpu_rdata_valid);
        check_value("cpu_rdata", ref_mem[addr], cpu_rdata);
        if (exp_hit) begin
            check_true(n == 2, "read hit did not answer one cycle after the request");
            check_true(n_bus_req == req0, "read hit raised bus_req");
        end else begin
            check_true(n_lv2_rd != rd0, "read miss raised no lv2_rd");
            check_true(n_bus_rd != brd0, "read miss raised no bus_rd_out");
        end
        @(posedge clk);
        cpu_rd <= 1'b0;
    endtask

    task automatic cpu_write(input addr_t addr, input data_t data, input logic exp_inv);
        int inv0;
        @(negedge clk);
        inv0 = n_inv;
        @(posedge clk);
        cpu_wr    <= 1'b1;
        cpu_addr  <= addr;
        cpu_wdata <= data;
        do begin
            @(negedge clk);
        end while (!cpu_wr_done);
        ref_mem[addr] = data;
        check_true((n_inv != inv0) == exp_inv, "bus_inv_out use does not match the line state");
        @(posedge clk);
        cpu_wr <= 1'b0;
    endtask

    task automatic snoop_pulse(input addr_t addr, input logic inv, input logic exp_hit);
        @(posedge clk);
        snoop_rd   <= !inv;
        snoop_inv  <= inv;
        snoop_addr <= addr;
        @(posedge clk);
        snoop_rd  <= 1'b0;
        snoop_inv <= 1'b0;
        @(negedge clk);
        if (inv) begin
            check_value("inval_done", 32'h1, 32'(inval_done));
        end else begin
            check_value("snoop_data_valid", 32'(exp_hit), 32'(snoop_data_valid));
            check_value("shared_local", 32'(exp_hit), 32'(shared_local));
            if (exp_hit) begin
                check_value("snoop_data", ref_mem[addr], snoop_data);
            end
        end
    endtask

    initial begin
        #(NUM_OPS * 200 * 40);
        $display("watchdog expired before the tests finished");
        $display("Done: errors found");
        $finish;
    end

    initial begin
        int wr0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        for (int a = 0; a < (1 << 16); a++) begin
            ref_mem[a] = l2_mem[a];
        end
        @(negedge clk);
        check_value("control outputs", 32'h0, 32'({cpu_rdata_valid, cpu_wr_done, bus_req,
            bus_rd_out, bus_inv_out, lv2_rd, lv2_wr, shared_local, snoop_data_valid,
            inval_done}));

        // read miss then hit
        cpu_read(16'h1230, 1'b0);
        cpu_read(16'h1230, 1'b1);

        // writes to exclusive and shared lines then a write miss
        cpu_read(16'h0451, 1'b0);
        cpu_write(16'h0451, 32'h5a5a_0451, 1'b0);
        cpu_read(16'h0451, 1'b1);
        fill_shared = 1'b1;
        cpu_read(16'h0782, 1'b0);
        cpu_write(16'h0782, 32'hc3c3_0782, 1'b1);
        cpu_read(16'h0782, 1'b1);
        cpu_write(16'h0ab3, 32'h1234_0ab3, 1'b1);
        cpu_read(16'h0ab3, 1'b1);
        fill_shared = 1'b0;

        // modified victim written back before the fill
        wr0 = n_lv2_wr;
        cpu_read(16'h0991, 1'b0);
        check_true(n_lv2_wr != wr0, "conflict miss wrote nothing back");
        check_value("bus_addr", 32'h0451, 32'(last_wr_addr));
        check_value("lv2_wdata", ref_mem[16'h0451], last_wr_data);
        check_true(last_wr_cyc < last_rd_cyc, "write-back came after the fill");
        check_value("l2_mem", ref_mem[16'h0451], l2_mem[16'h0451]);

        // snoops
        snoop_pulse(16'h0991, 1'b0, 1'b1);
        snoop_pulse(16'h0ff5, 1'b0, 1'b0);
        snoop_pulse(16'h0782, 1'b0, 1'b1);
        snoop_pulse(16'h1230, 1'b1, 1'b1);
        snoop_pulse(16'h0ff6, 1'b1, 1'b0);
        cpu_read(16'h1230, 1'b0);

        repeat (4) @(posedge clk);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
